// ==== list.f ====
common/main_mem_pkg.sv
common/bank_port_if.sv
hw/main_mem/main_mem_wr_port.sv
hw/main_mem/main_mem_bank.sv
hw/main_mem/main_mem_rd_port.sv
hw/main_mem/main_mem.sv
sim/main_mem_sva.sv
sim/main_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= main_mem_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero on any $fatal
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/main_mem_tb.sv ====
`timescale 1ns/1ps

module main_mem_tb;

  typedef main_mem_pkg::mem_mode_e mode_t;

  localparam int CLK_PERIOD   = 20;
  localparam int RST_CYCLES   = 10;
  localparam int FLUSH        = 3;
  localparam int B_ENTRIES    = 8 * 336;
  localparam int CELL_ENTRIES = 25 + 3 * 8 + 2 * 4;
  localparam int N_COL_WR     = 48;
  localparam int TEST_CYCLES  = 26 + (2 * B_ENTRIES + FLUSH) + 19
                                + (N_COL_WR + 2 * B_ENTRIES + FLUSH) + (2 * CELL_ENTRIES + FLUSH);
  localparam int WATCHDOG_CYCLES = RST_CYCLES + TEST_CYCLES + 20;

  logic        clk;
  logic        rst;
  logic        wr_en;
  mode_t       wr_mode;
  logic [13:0] wr_index;
  logic [63:0] wr_data;
  logic [13:0] wr_index_next;
  logic        wr_has_next;
  logic        rd_en;
  mode_t       rd_mode;
  logic [13:0] rd_index;
  logic [13:0] rd_index_next;
  logic        rd_has_next;
  logic        rd_valid;
  logic [63:0] rd_data;

  logic [31:0] lcg_state;
  logic [63:0] model [512][8]; // column, lane
  logic        pipe_en [$];
  logic [63:0] pipe_data [$];
  logic [16:0] pipe_tag [$];   // mode and index of each read

  main_mem dut (
    .clk             (clk),
    .i_rst           (rst),
    .i_wr_en         (wr_en),
    .i_wr_mode       (wr_mode),
    .i_wr_index      (wr_index),
    .i_wr_data       (wr_data),
    .o_wr_index_next (wr_index_next),
    .o_wr_has_next   (wr_has_next),
    .i_rd_en         (rd_en),
    .i_rd_mode       (rd_mode),
    .i_rd_index      (rd_index),
    .o_rd_index_next (rd_index_next),
    .o_rd_has_next   (rd_has_next),
    .o_rd_valid      (rd_valid),
    .o_rd_data       (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [13:0] exp_last(input mode_t mode);
    case (mode)
      main_mem_pkg::b_row:    return 14'd3919; // lane 7, column 335
      main_mem_pkg::b_col:    return 14'd2687;
      main_mem_pkg::ss_state: return 14'd24;
      main_mem_pkg::rng_state, main_mem_pkg::salt, main_mem_pkg::seed_se: return 14'd7;
      default:                return 14'd3;
    endcase
  endfunction

  function automatic logic [13:0] exp_next(input mode_t mode, input logic [13:0] idx);
    if (mode == main_mem_pkg::b_row && idx[8:0] == 9'd335) begin
      return {idx[13:9] + 5'd1, 9'd0};
    end
    return idx + 14'd1;
  endfunction

  function automatic logic [8:0] cell_base(input mode_t mode);
    case (mode)
      main_mem_pkg::ss_state:  return 9'd420;
      main_mem_pkg::rng_state: return 9'd426;
      main_mem_pkg::salt:      return 9'd427;
      main_mem_pkg::seed_se:   return 9'd428;
      main_mem_pkg::pkh:       return 9'd429;
      default:                 return 9'd431;
    endcase
  endfunction

  task automatic model_write(input mode_t mode, input logic [13:0] idx, input logic [63:0] data);
    logic [2:0] lane;
    int         slot;
    slot = int'(idx[2:1]);
    case (mode)
      main_mem_pkg::b_row: model[idx[8:0]][idx[11:9]] = data;
      main_mem_pkg::b_col: begin
        for (int r = 0; r < 4; r++) begin
          lane = 3'((idx[0] ? 4 : 0) + r); // element r lands in lane r of the half
          model[idx[11:3]][lane][slot*16 +: 16] = data[r*16 +: 16];
        end
      end
      default: model[cell_base(mode) + idx[11:3]][idx[2:0]] = data;
    endcase
  endtask

  function automatic logic [63:0] model_read(input mode_t mode, input logic [13:0] idx);
    logic [63:0] word;
    logic [2:0]  lane;
    int          slot;
    word = '0;
    slot = int'(idx[2:1]);
    case (mode)
      main_mem_pkg::b_row: word = model[idx[8:0]][idx[11:9]];
      main_mem_pkg::b_col: begin
        for (int r = 0; r < 4; r++) begin
          lane = 3'((idx[0] ? 4 : 0) + r);
          word[r*16 +: 16] = model[idx[11:3]][lane][slot*16 +: 16];
        end
      end
      default: word = model[cell_base(mode) + idx[11:3]][idx[2:0]];
    endcase
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // drive and check

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_step(input mode_t mode, input logic [13:0] idx,
                            input logic [13:0] next, input logic has);
    check_eq(64'(next), 64'(exp_next(mode, idx)), $sformatf("next index of %0d", idx));
    check_eq(64'(has), 64'(idx != exp_last(mode)), $sformatf("has next at %0d", idx));
  endtask

  // one clock: apply inputs now, then check the read issued two falling edges ago
  task automatic run_cycle(input logic r_en, input mode_t r_mode, input logic [13:0] r_idx,
                           input logic w_en, input mode_t w_mode, input logic [13:0] w_idx,
                           input logic [63:0] w_data);
    logic        exp_en;
    logic [63:0] exp_data;
    logic [16:0] tag;
    rd_en    = r_en;
    rd_mode  = r_mode;
    rd_index = r_idx;
    wr_en    = w_en;
    wr_mode  = w_mode;
    wr_index = w_idx;
    wr_data  = w_data;
    pipe_en.push_back(r_en);
    pipe_data.push_back(r_en ? model_read(r_mode, r_idx) : 64'd0);
    pipe_tag.push_back({r_mode, r_idx});
    if (w_en) model_write(w_mode, w_idx, w_data);
    @(negedge clk);
    if (pipe_en.size() > 1) begin
      exp_en   = pipe_en.pop_front();
      exp_data = pipe_data.pop_front();
      tag      = pipe_tag.pop_front();
      check_eq(64'(rd_valid), 64'(exp_en), "read valid");
      if (exp_en) begin
        check_eq(rd_data, exp_data,
                 $sformatf("read data mode %0d index %0d", tag[16:14], tag[13:0]));
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) run_cycle(1'b0, main_mem_pkg::b_row, '0, 1'b0, main_mem_pkg::b_row, '0, '0);
  endtask

  task automatic read_at(input mode_t mode, input logic [13:0] idx);
    run_cycle(1'b1, mode, idx, 1'b0, mode, idx, '0);
  endtask

  // walks a mode from index 0 with the DUT's own stepper until has_next drops
  task automatic step_range(input mode_t mode, input bit write, input int exp_count);
    logic [13:0] idx;
    logic [31:0] hi;
    logic [31:0] lo;
    int          count;
    bit          more;
    idx   = '0;
    count = 0;
    more  = 1'b1;
    while (more) begin
      hi = lcg_next();
      lo = lcg_next();
      if (write) begin
        run_cycle(1'b0, mode, idx, 1'b1, mode, idx, {mode, idx, hi, lo[14:0]}); // unique per entry
        check_step(mode, idx, wr_index_next, wr_has_next);
        more = wr_has_next;
        idx  = wr_index_next;
      end else begin
        read_at(mode, idx);
        check_step(mode, idx, rd_index_next, rd_has_next);
        more = rd_has_next;
        idx  = rd_index_next;
      end
      count++;
    end
    check_eq(64'(count), 64'(exp_count), "entries stepped");
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic test_index_steps();
    mode_t mode;
    logic [13:0] probes [5];
    for (int m = 0; m < 8; m++) begin
      mode      = mode_t'(m);
      probes[0] = '0;
      probes[1] = exp_last(mode) >> 1;
      probes[2] = exp_last(mode);
      probes[3] = 14'd335;  // end of lane 0
      probes[4] = 14'd1871; // end of lane 3
      for (int p = 0; p < ((mode == main_mem_pkg::b_row) ? 5 : 3); p++) begin
        run_cycle(1'b0, mode, probes[p], 1'b0, mode, probes[p], '0);
        check_step(mode, probes[p], rd_index_next, rd_has_next);
        check_step(mode, probes[p], wr_index_next, wr_has_next);
      end
    end
  endtask

  task automatic test_b_row_stream();
    step_range(main_mem_pkg::b_row, 1'b1, B_ENTRIES);
    step_range(main_mem_pkg::b_row, 1'b0, B_ENTRIES);
    idle(FLUSH);
  endtask

  task automatic test_read_valid();
    idle(3);
    read_at(main_mem_pkg::b_row, 14'd5);
    idle(4);
    read_at(main_mem_pkg::b_row, 14'd6); // two in flight
    read_at(main_mem_pkg::b_row, 14'd7);
    idle(3);
    read_at(main_mem_pkg::b_row, 14'd8);
    idle(1);
    read_at(main_mem_pkg::b_row, 14'd9);
    idle(FLUSH);
  endtask

  task automatic test_b_col_writes();
    logic [13:0] idx;
    repeat (N_COL_WR) begin
      idx = 14'(lcg_next() % 32'd2688);
      run_cycle(1'b0, main_mem_pkg::b_row, '0, 1'b1, main_mem_pkg::b_col, idx,
                {lcg_next(), lcg_next()});
    end
    step_range(main_mem_pkg::b_col, 1'b0, B_ENTRIES);
    step_range(main_mem_pkg::b_row, 1'b0, B_ENTRIES);
    idle(FLUSH);
  endtask

  task automatic test_cell_regions();
    mode_t mode;
    for (int m = 2; m < 8; m++) begin
      mode = mode_t'(m);
      step_range(mode, 1'b1, int'(exp_last(mode)) + 1);
    end
    for (int m = 2; m < 8; m++) begin
      mode = mode_t'(m);
      step_range(mode, 1'b0, int'(exp_last(mode)) + 1); // later regions would have clobbered
    end
    idle(FLUSH);
  endtask

  initial begin
    lcg_state = 32'he4e9_4f4f;
    rst       = 1'b1;
    wr_en     = 1'b0;
    wr_mode   = main_mem_pkg::b_row;
    wr_index  = '0;
    wr_data   = '0;
    rd_en     = 1'b0;
    rd_mode   = main_mem_pkg::b_row;
    rd_index  = '0;
    pipe_en.push_back(1'b0); // cycle before the first drive carries no read
    pipe_data.push_back('0);
    pipe_tag.push_back('0);
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;

    test_index_steps();
    test_b_row_stream();
    test_read_valid();
    test_b_col_writes();
    test_cell_regions();

    $display("sim passed");
    $finish;
  end

endmodule

// ==== sim/main_mem_sva.sv ====
`timescale 1ns/1ps

module main_mem_sva (
  input logic                                                         clk,
  input logic                                                         i_rst,
  input logic                                                         rd_en,
  input logic                                                         rd_valid,
  input logic [main_mem_pkg::N_LANES-1:0]                             rd_lane_en,
  input logic [main_mem_pkg::N_LANES-1:0]                             rd_byte_en,
  input logic                                                         wr_en,
  input logic [main_mem_pkg::N_LANES-1:0]                             wr_lane_en,
  input logic [main_mem_pkg::N_LANES-1:0][main_mem_pkg::LANE_W-1:0]   rdata
);

  localparam int N_BYTES = main_mem_pkg::LANE_W / main_mem_pkg::BYTE_W;

  a_rd_latency: assert property (@(posedge clk) disable iff (i_rst)
    rd_valid == $past(rd_en, 2))
    else $error("read valid does not follow read enable by two cycles");

  // one lane for row and cells, a half bank for column access
  a_wr_lanes: assert property (@(posedge clk) disable iff (i_rst)
    wr_en |-> ($onehot(wr_lane_en) || wr_lane_en == 8'h0f || wr_lane_en == 8'hf0))
    else $error("write lane enables are not a single lane or a half bank");

  for (genvar l = 0; l < main_mem_pkg::N_LANES; l++) begin : g_lane
    for (genvar b = 0; b < N_BYTES; b++) begin : g_byte
      a_masked: assert property (@(posedge clk) disable iff (i_rst)
        !($past(rd_en, 2) && $past(rd_lane_en[l], 2) && $past(rd_byte_en[b], 2))
        |-> rdata[l][b*main_mem_pkg::BYTE_W +: main_mem_pkg::BYTE_W] == '0)
        else $error("disabled read byte is not zero");
    end
  end

endmodule

bind main_mem_bank main_mem_sva u_sva (
  .clk        (clk),
  .i_rst      (i_rst),
  .rd_en      (rd.en),
  .rd_valid   (rd_en_d2),
  .rd_lane_en (rd.req.lane_en),
  .rd_byte_en (rd.req.byte_en),
  .wr_en      (wr.en),
  .wr_lane_en (wr.req.lane_en),
  .rdata      (rd.rdata)
);

// ==== hw/main_mem/main_mem.sv ====
`timescale 1ns/1ps

module main_mem (
  input  logic                                clk,
  input  logic                                i_rst,

  // write side
  input  logic                                i_wr_en,
  input  main_mem_pkg::mem_mode_e             i_wr_mode,
  input  logic [main_mem_pkg::INDEX_W-1:0]    i_wr_index,
  input  logic [main_mem_pkg::LANE_W-1:0]     i_wr_data,
  output logic [main_mem_pkg::INDEX_W-1:0]    o_wr_index_next,
  output logic                                o_wr_has_next,

  // read side
  input  logic                                i_rd_en,
  input  main_mem_pkg::mem_mode_e             i_rd_mode,
  input  logic [main_mem_pkg::INDEX_W-1:0]    i_rd_index,
  output logic [main_mem_pkg::INDEX_W-1:0]    o_rd_index_next,
  output logic                                o_rd_has_next,
  output logic                                o_rd_valid,
  output logic [main_mem_pkg::LANE_W-1:0]     o_rd_data
);

  bank_port_if wr_bus ();
  bank_port_if rd_bus ();

  main_mem_wr_port u_wr_port (
    .i_en         (i_wr_en),
    .i_mode       (i_wr_mode),
    .i_index      (i_wr_index),
    .i_data       (i_wr_data),
    .o_index_next (o_wr_index_next),
    .o_has_next   (o_wr_has_next),
    .bank         (wr_bus.producer)
  );

  main_mem_bank u_bank (
    .clk   (clk),
    .i_rst (i_rst),
    .wr    (wr_bus.bank),
    .rd    (rd_bus.bank)
  );

  main_mem_rd_port u_rd_port (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_en         (i_rd_en),
    .i_mode       (i_rd_mode),
    .i_index      (i_rd_index),
    .o_index_next (o_rd_index_next),
    .o_has_next   (o_rd_has_next),
    .o_valid      (o_rd_valid),
    .o_data       (o_rd_data),
    .bank         (rd_bus.producer)
  );

endmodule

// ==== hw/main_mem/main_mem_rd_port.sv ====
`timescale 1ns/1ps

module main_mem_rd_port (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic                                i_en,
  input  main_mem_pkg::mem_mode_e             i_mode,
  input  logic [main_mem_pkg::INDEX_W-1:0]    i_index,
  output logic [main_mem_pkg::INDEX_W-1:0]    o_index_next,
  output logic                                o_has_next,
  output logic                                o_valid,
  output logic [main_mem_pkg::LANE_W-1:0]     o_data,
  bank_port_if.producer                       bank
);

  localparam int N_LANES = main_mem_pkg::N_LANES;
  localparam int LANE_W  = main_mem_pkg::LANE_W;
  localparam int ELEM_W  = main_mem_pkg::ELEM_W;
  localparam int HALF    = N_LANES / 2;
  localparam int N_SLOTS = LANE_W / ELEM_W;

  logic                    en_d1;
  logic                    en_d2;
  main_mem_pkg::mem_mode_e mode_d1;
  main_mem_pkg::mem_mode_e mode_d2;
  logic [LANE_W-1:0]       row_merge;
  logic [LANE_W-1:0]       col_merge;

  ////////////////////////////////////////////////////////////
  // request

  assign bank.en    = i_en;
  assign bank.req   = main_mem_pkg::map_access(i_mode, i_index);
  assign bank.wdata = '0; // read side carries no write data

  assign o_index_next = main_mem_pkg::step_index(i_mode, i_index);
  assign o_has_next   = i_index != main_mem_pkg::last_index(i_mode);

  ////////////////////////////////////////////////////////////
  // mode follows the read pipeline

  always_ff @(posedge clk) begin
    if (i_rst) begin
      en_d1   <= 1'b0;
      en_d2   <= 1'b0;
      mode_d1 <= main_mem_pkg::b_row;
      mode_d2 <= main_mem_pkg::b_row;
    end else begin
      en_d1   <= i_en;
      en_d2   <= en_d1;
      mode_d1 <= i_mode;
      mode_d2 <= mode_d1;
    end
  end

  assign o_valid = en_d2;

  ////////////////////////////////////////////////////////////
  // lane merge, disabled bytes arrive as zero

  always_comb begin
    row_merge = '0;
    for (int l = 0; l < N_LANES; l++) begin
      row_merge |= bank.rdata[l]; // one lane at most
    end
  end

  // element r gathers every slot of lanes r and r+4
  always_comb begin
    col_merge = '0;
    for (int r = 0; r < HALF; r++) begin
      for (int s = 0; s < N_SLOTS; s++) begin
        col_merge[r*ELEM_W +: ELEM_W] |= bank.rdata[r][s*ELEM_W +: ELEM_W]
                                       | bank.rdata[r+HALF][s*ELEM_W +: ELEM_W];
      end
    end
  end

  assign o_data = (mode_d2 == main_mem_pkg::b_col) ? col_merge : row_merge;

endmodule

// ==== hw/main_mem/main_mem_bank.sv ====
`timescale 1ns/1ps

module main_mem_bank (
  input  logic      clk,
  input  logic      i_rst,
  bank_port_if.bank wr,
  bank_port_if.bank rd
);

  localparam int N_LANES = main_mem_pkg::N_LANES;
  localparam int LANE_W  = main_mem_pkg::LANE_W;
  localparam int BYTE_W  = main_mem_pkg::BYTE_W;
  localparam int N_COLS  = main_mem_pkg::N_COLS;
  localparam int N_BYTES = LANE_W / BYTE_W;

  logic               rd_en_d1;
  logic               rd_en_d2;
  logic [N_LANES-1:0] rd_lane_en_d1;
  logic [N_LANES-1:0] rd_lane_en_d2;
  logic [N_LANES-1:0] rd_byte_en_d1;
  logic [N_LANES-1:0] rd_byte_en_d2;

  ////////////////////////////////////////////////////////////
  // enable pipeline for output masking

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_en_d1      <= 1'b0;
      rd_en_d2      <= 1'b0;
      rd_lane_en_d1 <= '0;
      rd_lane_en_d2 <= '0;
      rd_byte_en_d1 <= '0;
      rd_byte_en_d2 <= '0;
    end else begin
      rd_en_d1      <= rd.en;
      rd_en_d2      <= rd_en_d1;
      rd_lane_en_d1 <= rd.req.lane_en;
      rd_lane_en_d2 <= rd_lane_en_d1;
      rd_byte_en_d1 <= rd.req.byte_en;
      rd_byte_en_d2 <= rd_byte_en_d1;
    end
  end

  assign wr.rdata = '0; // write side never returns data

  ////////////////////////////////////////////////////////////
  // RAM lanes

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    logic [LANE_W-1:0] mem [N_COLS];
    logic [LANE_W-1:0] rd_q1;
    logic [LANE_W-1:0] rd_q2;

    always_ff @(posedge clk) begin
      if (wr.en && wr.req.lane_en[l]) begin
        for (int b = 0; b < N_BYTES; b++) begin
          if (wr.req.byte_en[b]) begin
            mem[wr.req.column][b*BYTE_W +: BYTE_W] <= wr.wdata[l][b*BYTE_W +: BYTE_W];
          end
        end
      end
    end

    always_ff @(posedge clk) begin
      if (rd.en && rd.req.lane_en[l]) begin
        rd_q1 <= mem[rd.req.column]; // old data on same-cycle write
      end
      if (rd_en_d1) begin
        rd_q2 <= rd_q1; // output register
      end
    end

    for (genvar b = 0; b < N_BYTES; b++) begin : g_byte
      assign rd.rdata[l][b*BYTE_W +: BYTE_W] =
        rd_q2[b*BYTE_W +: BYTE_W] & {BYTE_W{rd_en_d2 & rd_lane_en_d2[l] & rd_byte_en_d2[b]}};
    end
  end

endmodule

// ==== hw/main_mem/main_mem_wr_port.sv ====
`timescale 1ns/1ps

module main_mem_wr_port (
  input  logic                                i_en,
  input  main_mem_pkg::mem_mode_e             i_mode,
  input  logic [main_mem_pkg::INDEX_W-1:0]    i_index,
  input  logic [main_mem_pkg::LANE_W-1:0]     i_data,
  output logic [main_mem_pkg::INDEX_W-1:0]    o_index_next,
  output logic                                o_has_next,
  bank_port_if.producer                       bank
);

  localparam int HALF     = main_mem_pkg::N_LANES / 2;
  localparam int N_SLOTS  = main_mem_pkg::LANE_W / main_mem_pkg::ELEM_W;
  localparam int ELEM_W   = main_mem_pkg::ELEM_W;

  ////////////////////////////////////////////////////////////
  // request

  assign bank.en  = i_en;
  assign bank.req = main_mem_pkg::map_access(i_mode, i_index);

  assign o_index_next = main_mem_pkg::step_index(i_mode, i_index);
  assign o_has_next   = i_index != main_mem_pkg::last_index(i_mode);

  ////////////////////////////////////////////////////////////
  // lane data

  // column writes: lanes r and r+4 both carry element r in every slot,
  // byte enables then pick the slot and lane enables pick the half
  for (genvar l = 0; l < main_mem_pkg::N_LANES; l++) begin : g_lane
    localparam int ELEM = l % HALF;

    logic [ELEM_W-1:0] col_elem;

    assign col_elem = i_data[ELEM*ELEM_W +: ELEM_W];

    assign bank.wdata[l] = (i_mode == main_mem_pkg::b_col) ? {N_SLOTS{col_elem}}
                                                           : i_data; // row and cells
  end

endmodule

// ==== common/bank_port_if.sv ====
`timescale 1ns/1ps

interface bank_port_if;

  logic                      en;  // request strobe, no handshake
  main_mem_pkg::bank_req_t   req;

  // per-lane words, write side
  logic [main_mem_pkg::N_LANES-1:0][main_mem_pkg::LANE_W-1:0] wdata;

  // per-lane words, read side, two cycles after en
  logic [main_mem_pkg::N_LANES-1:0][main_mem_pkg::LANE_W-1:0] rdata;

  modport producer (
    output en,
    output req,
    output wdata,
    input  rdata
  );

  modport bank (
    input  en,
    input  req,
    input  wdata,
    output rdata
  );

endinterface

// ==== common/main_mem_pkg.sv ====
package main_mem_pkg;

  ////////////////////////////////////////////////////////////
  // geometry

  localparam int N_LANES = 8;
  localparam int LANE_W  = 64;
  localparam int BYTE_W  = 8;
  localparam int N_COLS  = 512;
  localparam int COL_W   = 9;
  localparam int ELEM_W  = 16;
  localparam int INDEX_W = 14;
  localparam int B_COLS  = 336; // matrix B columns per lane

  localparam logic [COL_W-1:0] OFF_B         = 9'd0;
  localparam logic [COL_W-1:0] OFF_SS_STATE  = 9'd420;
  localparam logic [COL_W-1:0] OFF_RNG_STATE = 9'd426;
  localparam logic [COL_W-1:0] OFF_SALT      = 9'd427;
  localparam logic [COL_W-1:0] OFF_SEED_SE   = 9'd428;
  localparam logic [COL_W-1:0] OFF_PKH       = 9'd429;
  localparam logic [COL_W-1:0] OFF_K         = 9'd431;

  typedef enum logic [2:0] {
    b_row, b_col, ss_state, rng_state, salt, seed_se, pkh, k
  } mem_mode_e;

  typedef struct packed {
    logic [COL_W-1:0]   column;
    logic [N_LANES-1:0] lane_en;
    logic [N_LANES-1:0] byte_en;
  } bank_req_t;

  ////////////////////////////////////////////////////////////
  // address mapping and index stepping

  function automatic logic [COL_W-1:0] region_offset(input mem_mode_e mode);
    case (mode)
      ss_state:  return OFF_SS_STATE;
      rng_state: return OFF_RNG_STATE;
      salt:      return OFF_SALT;
      seed_se:   return OFF_SEED_SE;
      pkh:       return OFF_PKH;
      k:         return OFF_K;
      default:   return OFF_B; // both B views
    endcase
  endfunction

  function automatic bank_req_t map_access(input mem_mode_e mode,
                                           input logic [INDEX_W-1:0] index);
    bank_req_t req;
    case (mode)
      b_row: begin
        req.column  = region_offset(mode) + index[8:0];
        req.lane_en = N_LANES'(1) << index[11:9];
        req.byte_en = '1;
      end
      b_col: begin
        req.column  = region_offset(mode) + index[11:3];
        req.lane_en = index[0] ? 8'hf0 : 8'h0f; // half bank
        req.byte_en = N_LANES'(3) << {index[2:1], 1'b0}; // one 16-bit slot
      end
      default: begin
        req.column  = region_offset(mode) + index[11:3];
        req.lane_en = N_LANES'(1) << index[2:0];
        req.byte_en = '1;
      end
    endcase
    return req;
  endfunction

  function automatic logic [INDEX_W-1:0] last_index(input mem_mode_e mode);
    case (mode)
      b_row:                    return INDEX_W'((N_LANES - 1) * N_COLS + B_COLS - 1);
      b_col:                    return INDEX_W'(N_LANES * B_COLS - 1);
      ss_state:                 return INDEX_W'(24);
      rng_state, salt, seed_se: return INDEX_W'(7);
      default:                  return INDEX_W'(3); // pkh, k
    endcase
  endfunction

  function automatic logic [INDEX_W-1:0] step_index(input mem_mode_e mode,
                                                    input logic [INDEX_W-1:0] index);
    if (mode == b_row && index[COL_W-1:0] == COL_W'(B_COLS - 1)) begin
      return {index[INDEX_W-1:COL_W] + 1'b1, {COL_W{1'b0}}}; // next lane, column 0
    end
    return index + 1'b1;
  endfunction

endpackage
